//--- sim.f
logic/core_pkg.sv
logic/rename_stage.sv
logic/issue_stage.sv
logic/exec_units.sv
logic/reorder_buffer.sv
logic/ooo_core.sv
testbench/core_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the core testbench with verilator, run it, scan the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module core_tb -o core_tb_sim

./obj_dir/core_tb_sim | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
  echo "simulation reported failures, see sim.log"
  exit 1
fi
echo "simulation finished without failures"

//--- testbench/core_tb.sv
`timescale 1ns/10ps

module core_tb
  import core_pkg::*;
();

  // 330 ops, each done well inside 12 cycles, plus reset and idle checks
  localparam int TOTAL_OPS  = 8 + 10 + 12 + 300;
  localparam int MAX_CYCLES = 12 * TOTAL_OPS + 40;

  logic         clock;
  logic         reset;
  logic         dispatch_valid;
  dispatch_op_t dispatch_op;
  logic         dispatch_ready;
  logic         commit_valid;
  arch_reg_t    commit_dest;
  data_t        commit_value;

  // reference model, expected commits in program order
  data_t       arch_regs [NUM_ARCH];
  arch_reg_t   exp_dest [$];
  data_t       exp_value [$];
  int          accepted = 0;
  int          committed = 0;
  int          commit_errors = 0;
  int          stall_cycles = 0;
  int          flow_errors = 0;
  int          tests_run = 0;
  int          test_err_start;
  int          test_com_start;
  int          cycle_count;
  logic [31:0] rng_state = 32'h7906;

  ooo_core #(
    .NUM_ARCH(NUM_ARCH), .NUM_PHYS(NUM_PHYS), .ROB_DEPTH(ROB_DEPTH),
    .IQ_DEPTH(IQ_DEPTH), .MUL_STAGES(MUL_STAGES)
  ) UUT (
    .clock(clock), .reset(reset),
    .dispatch_valid(dispatch_valid), .dispatch_op(dispatch_op),
    .dispatch_ready(dispatch_ready),
    .commit_valid(commit_valid), .commit_dest(commit_dest), .commit_value(commit_value)
  );

  always #5 clock = ~clock;

  ////////////////////
  // helpers
  ////////////////////

  // lcg, upper half only since the low bits repeat quickly
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return {16'h0000, rng_state[31:16]};
  endfunction

  // result rules of the five operations
  function automatic data_t model_result(op_kind_t kind, data_t a, data_t b);
    case (kind)
      op_add:  return a + b;
      op_sub:  return a - b;
      op_and:  return a & b;
      op_xor:  return a ^ b;
      default: return a * b;
    endcase
  endfunction

  function automatic dispatch_op_t make_op(op_kind_t kind, arch_reg_t dest, arch_reg_t src_a,
                                           arch_reg_t src_b, logic use_imm, data_t imm);
    dispatch_op_t op;
    op.kind    = kind;
    op.dest    = dest;
    op.src_a   = src_a;
    op.src_b   = src_b;
    op.use_imm = use_imm;
    op.imm     = imm;
    return op;
  endfunction

  function automatic dispatch_op_t random_op();
    logic [2:0] k;
    k = 3'(next_rand() % 32'd5);
    return make_op(op_kind_t'(k), 3'(next_rand()), 3'(next_rand()), 3'(next_rand()),
                   1'(next_rand()), {16'(next_rand()), 16'(next_rand())});
  endfunction

  // hold the op until the edge that takes it
  task automatic send_op(input dispatch_op_t op);
    dispatch_valid <= 1'b1;
    dispatch_op    <= op;
    @(posedge clock);
    while (!dispatch_ready) @(posedge clock);
  endtask

  task automatic idle_cycles(input int n);
    if (n > 0) begin
      dispatch_valid <= 1'b0;
      repeat (n) @(posedge clock);
    end
  endtask

  // wait until every accepted op has committed
  task automatic wait_drain();
    dispatch_valid <= 1'b0;
    @(posedge clock);
    while (exp_dest.size() != 0) @(posedge clock);
    @(posedge clock);
  endtask

  task automatic begin_test();
    test_err_start = commit_errors + flow_errors;
    test_com_start = committed;
  endtask

  task automatic end_test(input string name, input int expected_commits);
    int errs;
    assert (committed - test_com_start == expected_commits) else begin
      $display("%s: %0d commits seen where %0d operations were sent",
               name, committed - test_com_start, expected_commits);
      flow_errors++;
    end
    errs = commit_errors + flow_errors - test_err_start;
    tests_run++;
    $display("test %0d %s: %0d commits, %0d errors", tests_run, name,
             committed - test_com_start, errs);
  endtask

  ////////////////////
  // commit monitor and model
  ////////////////////

  always @(posedge clock) begin : monitor
    data_t b;
    data_t r;
    if (reset) begin
      for (int i = 0; i < NUM_ARCH; i++) begin
        arch_regs[i] = '0;
      end
    end else begin
      if (commit_valid) begin
        assert (exp_dest.size() != 0) else begin
          $display("commit at time %0t with no operation outstanding", $time);
          commit_errors++;
        end
        if (exp_dest.size() != 0) begin
          assert (commit_dest == exp_dest[0] && commit_value == exp_value[0]) else begin
            $display("[FAIL] time %0t: commit r%0d = %h, expected r%0d = %h", $time,
                     commit_dest, commit_value, exp_dest[0], exp_value[0]);
            commit_errors++;
          end
          exp_dest.delete(0);
          exp_value.delete(0);
        end
        committed++;
      end
      // accepted op applied in program order
      if (dispatch_valid && dispatch_ready) begin
        b = dispatch_op.use_imm ? dispatch_op.imm : arch_regs[dispatch_op.src_b];
        r = model_result(dispatch_op.kind, arch_regs[dispatch_op.src_a], b);
        arch_regs[dispatch_op.dest] = r;
        exp_dest.push_back(dispatch_op.dest);
        exp_value.push_back(r);
        accepted++;
      end
      if (dispatch_valid && !dispatch_ready) begin
        stall_cycles++;
      end
      assert (accepted - committed <= ROB_DEPTH) else begin
        $display("more than %0d operations in flight at time %0t", ROB_DEPTH, $time);
        commit_errors++;
      end
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    int stall_start;
    clock = 1'b0;
    reset <= 1'b1;
    dispatch_valid <= 1'b0;
    dispatch_op <= '0;
    repeat (16) @(posedge clock);
    reset <= 1'b0;

    // idle core after reset
    begin_test();
    repeat (20) begin
      @(posedge clock);
      assert (!commit_valid && dispatch_ready) else begin
        $display("[FAIL] time %0t: idle core shows commit_valid %b, dispatch_ready %b",
                 $time, commit_valid, dispatch_ready);
        flow_errors++;
      end
    end
    end_test("after reset", 0);

    // r_i gets its own immediate
    begin_test();
    for (int i = 0; i < 8; i++) begin
      send_op(make_op(op_add, 3'(i), 3'(i), 3'd0, 1'b1, 32'h101 * (i + 1)));
    end
    wait_drain();
    end_test("immediate adds", 8);

    // slow multiply overtaken by alu ops, then a chain through r1
    begin_test();
    send_op(make_op(op_mul, 3'd1, 3'd2, 3'd3, 1'b0, '0));
    send_op(make_op(op_add, 3'd4, 3'd5, 3'd0, 1'b1, 32'h11));
    send_op(make_op(op_xor, 3'd6, 3'd6, 3'd7, 1'b0, '0));
    send_op(make_op(op_sub, 3'd0, 3'd5, 3'd7, 1'b0, '0));
    send_op(make_op(op_mul, 3'd1, 3'd1, 3'd2, 1'b0, '0));
    send_op(make_op(op_add, 3'd1, 3'd1, 3'd0, 1'b1, 32'h5));
    send_op(make_op(op_mul, 3'd1, 3'd1, 3'd1, 1'b0, '0));
    send_op(make_op(op_sub, 3'd1, 3'd1, 3'd4, 1'b0, '0));
    send_op(make_op(op_mul, 3'd1, 3'd1, 3'd6, 1'b0, '0));
    send_op(make_op(op_and, 3'd2, 3'd1, 3'd0, 1'b1, 32'h00ff_ff00));
    wait_drain();
    end_test("out-of-order completion", 10);

    // dependent multiply burst must run out of room
    begin_test();
    stall_start = stall_cycles;
    for (int i = 0; i < 12; i++) begin
      send_op(make_op(op_mul, 3'd3, 3'd3, 3'd4, 1'b0, '0));
    end
    wait_drain();
    assert (stall_cycles > stall_start) else begin
      $display("dispatch_ready never dropped during the multiply burst");
      flow_errors++;
    end
    end_test("resource limits", 12);

    // random kinds, registers and gaps
    begin_test();
    for (int i = 0; i < 300; i++) begin
      send_op(random_op());
      idle_cycles(int'(next_rand() % 32'd4));
    end
    wait_drain();
    end_test("random stream", 300);

    $display("tests %0d, accepted %0d, committed %0d, errors %0d", tests_run, accepted,
             committed, commit_errors + flow_errors);
    if (commit_errors + flow_errors == 0 && accepted == committed) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // run limit
  initial begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("timeout: the run was still going after %0d cycles", MAX_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- logic/ooo_core.sv
`timescale 1ns/10ps

module ooo_core
  import core_pkg::*;
#(
  parameter int NUM_ARCH   = core_pkg::NUM_ARCH,
  parameter int NUM_PHYS   = core_pkg::NUM_PHYS,
  parameter int ROB_DEPTH  = core_pkg::ROB_DEPTH,
  parameter int IQ_DEPTH   = core_pkg::IQ_DEPTH,
  parameter int MUL_STAGES = core_pkg::MUL_STAGES
) (
  input  logic         clock,
  input  logic         reset,
  input  logic         dispatch_valid,
  input  dispatch_op_t dispatch_op,
  output logic         dispatch_ready,
  output logic         commit_valid,
  output arch_reg_t    commit_dest,
  output data_t        commit_value
);

  logic        accept;
  logic        free_nonempty;
  logic        iq_room;
  logic        rob_room;
  rob_idx_t    rob_tail;
  logic        free_valid;
  phys_tag_t   free_tag;
  logic        renamed_valid;
  renamed_op_t renamed;
  phys_tag_t   old_tag;
  arch_reg_t   renamed_dest;
  logic        issue_valid;
  issue_op_t   issue_op;
  cdb_t        cdb;

  ////////////////////
  // dispatch handshake
  ////////////////////

  // needs a free tag, a rob slot and a queue slot
  assign dispatch_ready = free_nonempty && rob_room && iq_room;
  assign accept         = dispatch_valid && dispatch_ready;

  rename_stage #(.NUM_ARCH(NUM_ARCH), .NUM_PHYS(NUM_PHYS)) u_rename (
    .clock(clock), .reset(reset),
    .accept(accept), .dispatch_op(dispatch_op), .rob_tail(rob_tail),
    .free_valid(free_valid), .free_tag(free_tag), .free_nonempty(free_nonempty),
    .renamed_valid(renamed_valid), .renamed(renamed),
    .old_tag(old_tag), .renamed_dest(renamed_dest)
  );

  issue_stage #(.NUM_PHYS(NUM_PHYS), .IQ_DEPTH(IQ_DEPTH), .MUL_STAGES(MUL_STAGES)) u_issue (
    .clock(clock), .reset(reset),
    .renamed_valid(renamed_valid), .renamed(renamed), .cdb(cdb),
    .iq_room(iq_room), .issue_valid(issue_valid), .issue_op(issue_op)
  );

  exec_units #(.MUL_STAGES(MUL_STAGES)) u_exec (
    .clock(clock), .reset(reset),
    .issue_valid(issue_valid), .issue_op(issue_op), .cdb(cdb)
  );

  reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
    .clock(clock), .reset(reset),
    .renamed_valid(renamed_valid), .renamed_dest(renamed_dest),
    .new_tag(renamed.tag_dest), .old_tag(old_tag), .cdb(cdb),
    .rob_tail(rob_tail), .rob_room(rob_room),
    .free_valid(free_valid), .free_tag(free_tag),
    .commit_valid(commit_valid), .commit_dest(commit_dest), .commit_value(commit_value)
  );

endmodule

//--- logic/reorder_buffer.sv
`timescale 1ns/10ps

module reorder_buffer
  import core_pkg::*;
#(
  parameter int ROB_DEPTH = core_pkg::ROB_DEPTH
) (
  input  logic      clock,
  input  logic      reset,
  input  logic      renamed_valid,
  input  arch_reg_t renamed_dest,
  input  phys_tag_t new_tag,
  input  phys_tag_t old_tag,
  input  cdb_t      cdb,
  output rob_idx_t  rob_tail,
  output logic      rob_room,
  output logic      free_valid,
  output phys_tag_t free_tag,
  output logic      commit_valid,
  output arch_reg_t commit_dest,
  output data_t     commit_value
);

  localparam int CNT_W = $clog2(ROB_DEPTH) + 1;

  arch_reg_t            rob_dest  [ROB_DEPTH];
  phys_tag_t            rob_new   [ROB_DEPTH];
  phys_tag_t            rob_old   [ROB_DEPTH];
  data_t                rob_value [ROB_DEPTH];
  logic [ROB_DEPTH-1:0] rob_done;
  rob_idx_t             head;
  rob_idx_t             tail;
  rob_idx_t             tail_inc;
  logic [CNT_W-1:0]     count;
  logic                 retire;
  logic                 bus_hit;

  assign tail_inc = (tail == rob_idx_t'(ROB_DEPTH - 1)) ? '0 : tail + 1'b1;

  // next op in rename gets the slot after the pending one
  assign rob_tail = renamed_valid ? tail_inc : tail;
  assign rob_room = (count + CNT_W'(renamed_valid)) < CNT_W'(ROB_DEPTH);

  // tag check guards against a stale index
  assign bus_hit = cdb.valid && (rob_new[cdb.rob_idx] == cdb.tag);

  ////////////////////
  // retire port
  ////////////////////

  assign retire       = (count != '0) && rob_done[head];
  assign commit_valid = retire;
  assign commit_dest  = rob_dest[head];
  assign commit_value = rob_value[head];
  // previous mapping of this dest is dead now
  assign free_valid   = retire;
  assign free_tag     = rob_old[head];

  always_ff @(posedge clock) begin
    if (reset) begin
      head     <= '0;
      tail     <= '0;
      count    <= '0;
      rob_done <= '0;
    end else begin
      // allocate at tail
      if (renamed_valid) begin
        rob_dest[tail] <= renamed_dest;
        rob_new[tail]  <= new_tag;
        rob_old[tail]  <= old_tag;
        rob_done[tail] <= 1'b0;
        tail           <= tail_inc;
      end
      // completion from the bus
      if (bus_hit) begin
        rob_done[cdb.rob_idx]  <= 1'b1;
        rob_value[cdb.rob_idx] <= cdb.value;
      end
      if (retire) begin
        head <= (head == rob_idx_t'(ROB_DEPTH - 1)) ? '0 : head + 1'b1;
      end
      if (renamed_valid && !retire) begin
        count <= count + 1'b1;
      end else if (!renamed_valid && retire) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- logic/exec_units.sv
`timescale 1ns/10ps

module exec_units
  import core_pkg::*;
#(
  parameter int MUL_STAGES = core_pkg::MUL_STAGES
) (
  input  logic      clock,
  input  logic      reset,
  input  logic      issue_valid,
  input  issue_op_t issue_op,
  output cdb_t      cdb
);

  cdb_t  alu_q;
  cdb_t  mul_pipe [MUL_STAGES];
  data_t alu_result;
  logic  is_mul;

  assign is_mul = (issue_op.kind == op_mul);

  ////////////////////
  // alu
  ////////////////////

  always_comb begin
    case (issue_op.kind)
      op_add:  alu_result = issue_op.value_a + issue_op.value_b;
      op_sub:  alu_result = issue_op.value_a - issue_op.value_b;
      op_and:  alu_result = issue_op.value_a & issue_op.value_b;
      op_xor:  alu_result = issue_op.value_a ^ issue_op.value_b;
      // multiplies never land here
      default: alu_result = '0;
    endcase
  end

  // single result register, on the bus next cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      alu_q.valid <= 1'b0;
    end else begin
      alu_q.valid   <= issue_valid && !is_mul;
      alu_q.tag     <= issue_op.tag_dest;
      alu_q.rob_idx <= issue_op.rob_idx;
      alu_q.value   <= alu_result;
    end
  end

  ////////////////////
  // multiplier pipe
  ////////////////////

  // product formed in stage 0, low word only
  // later stages just carry it along
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < MUL_STAGES; i++) begin
        mul_pipe[i].valid <= 1'b0;
      end
    end else begin
      mul_pipe[0].valid   <= issue_valid && is_mul;
      mul_pipe[0].tag     <= issue_op.tag_dest;
      mul_pipe[0].rob_idx <= issue_op.rob_idx;
      mul_pipe[0].value   <= issue_op.value_a * issue_op.value_b;
      for (int i = 1; i < MUL_STAGES; i++) begin
        mul_pipe[i] <= mul_pipe[i-1];
      end
    end
  end

  // issue side reserves slots, so only one of these is valid
  assign cdb = alu_q.valid ? alu_q : mul_pipe[MUL_STAGES-1];

endmodule

//--- logic/issue_stage.sv
`timescale 1ns/10ps

module issue_stage
  import core_pkg::*;
#(
  parameter int NUM_PHYS   = core_pkg::NUM_PHYS,
  parameter int IQ_DEPTH   = core_pkg::IQ_DEPTH,
  parameter int MUL_STAGES = core_pkg::MUL_STAGES
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        renamed_valid,
  input  renamed_op_t renamed,
  input  cdb_t        cdb,
  output logic        iq_room,
  output logic        issue_valid,
  output issue_op_t   issue_op
);

  localparam int IQ_PTR_W = $clog2(IQ_DEPTH);
  localparam int IQ_CNT_W = IQ_PTR_W + 1;

  renamed_op_t         iq_mem [IQ_DEPTH];
  logic [IQ_PTR_W-1:0] iq_head;
  logic [IQ_PTR_W-1:0] iq_tail;
  logic [IQ_CNT_W-1:0] iq_count;
  data_t               regfile [NUM_PHYS];
  logic [NUM_PHYS-1:0] tag_ready;
  // bit i set: bus taken i+1 cycles ahead by a multiply
  logic [MUL_STAGES-2:0] slot_busy;

  renamed_op_t head_op;
  logic        a_on_bus;
  logic        b_on_bus;
  logic        a_ready;
  logic        b_ready;
  logic        is_mul;

  assign head_op = iq_mem[iq_head];

  ////////////////////
  // wakeup and select
  ////////////////////

  // same-cycle bus value counts as ready
  assign a_on_bus = cdb.valid && (cdb.tag == head_op.tag_a);
  assign b_on_bus = cdb.valid && (cdb.tag == head_op.tag_b);
  assign a_ready  = tag_ready[head_op.tag_a] || a_on_bus;
  assign b_ready  = head_op.use_imm || tag_ready[head_op.tag_b] || b_on_bus;
  assign is_mul   = (head_op.kind == op_mul);

  // alu held back when its result slot belongs to a multiply
  assign issue_valid = (iq_count != '0) && a_ready && b_ready
                       && (is_mul || !slot_busy[0]);

  assign issue_op.kind     = head_op.kind;
  assign issue_op.value_a  = a_on_bus ? cdb.value : regfile[head_op.tag_a];
  assign issue_op.value_b  = head_op.use_imm ? head_op.imm :
                             b_on_bus ? cdb.value : regfile[head_op.tag_b];
  assign issue_op.tag_dest = head_op.tag_dest;
  assign issue_op.rob_idx  = head_op.rob_idx;

  // leave a place for the op still in the rename register
  assign iq_room = (iq_count + IQ_CNT_W'(renamed_valid)) < IQ_CNT_W'(IQ_DEPTH);

  ////////////////////
  // queue, ready bits, slots
  ////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      iq_head   <= '0;
      iq_tail   <= '0;
      iq_count  <= '0;
      tag_ready <= '1;
      slot_busy <= '0;
    end else begin
      if (renamed_valid) begin
        iq_mem[iq_tail] <= renamed;
        iq_tail <= (iq_tail == IQ_PTR_W'(IQ_DEPTH - 1)) ? '0 : iq_tail + 1'b1;
        // dest tag waits for its producer again
        tag_ready[renamed.tag_dest] <= 1'b0;
      end
      if (issue_valid) begin
        iq_head <= (iq_head == IQ_PTR_W'(IQ_DEPTH - 1)) ? '0 : iq_head + 1'b1;
      end
      if (renamed_valid && !issue_valid) begin
        iq_count <= iq_count + 1'b1;
      end else if (!renamed_valid && issue_valid) begin
        iq_count <= iq_count - 1'b1;
      end
      if (cdb.valid) begin
        tag_ready[cdb.tag] <= 1'b1;
      end
      slot_busy <= slot_busy >> 1;
      if (issue_valid && is_mul) begin
        slot_busy[MUL_STAGES-2] <= 1'b1;
      end
    end
  end

  // physical registers, arch state starts at zero
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < NUM_PHYS; i++) begin
        regfile[i] <= '0;
      end
    end else if (cdb.valid) begin
      regfile[cdb.tag] <= cdb.value;
    end
  end

endmodule

//--- logic/rename_stage.sv
`timescale 1ns/10ps

module rename_stage
  import core_pkg::*;
#(
  parameter int NUM_ARCH = core_pkg::NUM_ARCH,
  parameter int NUM_PHYS = core_pkg::NUM_PHYS
) (
  input  logic         clock,
  input  logic         reset,
  input  logic         accept,
  input  dispatch_op_t dispatch_op,
  input  rob_idx_t     rob_tail,
  input  logic         free_valid,
  input  phys_tag_t    free_tag,
  output logic         free_nonempty,
  output logic         renamed_valid,
  output renamed_op_t  renamed,
  output phys_tag_t    old_tag,
  output arch_reg_t    renamed_dest
);

  localparam int FL_PTR_W = $clog2(NUM_PHYS);
  localparam int FL_CNT_W = FL_PTR_W + 1;
  // tags left over once every arch reg owns one
  localparam int FL_INIT  = NUM_PHYS - NUM_ARCH;

  phys_tag_t           map_table [NUM_ARCH];
  phys_tag_t           free_fifo [NUM_PHYS];
  logic [FL_PTR_W-1:0] fl_head;
  logic [FL_PTR_W-1:0] fl_tail;
  logic [FL_CNT_W-1:0] fl_count;
  phys_tag_t           new_tag;

  // next free tag sits at the fifo head
  assign new_tag       = free_fifo[fl_head];
  assign free_nonempty = (fl_count != '0);

  ////////////////////
  // map table and free list
  ////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      // identity mapping, arch reg i on tag i
      for (int i = 0; i < NUM_ARCH; i++) begin
        map_table[i] <= phys_tag_t'(i);
      end
      // upper tags start out free
      for (int i = 0; i < NUM_PHYS; i++) begin
        free_fifo[i] <= phys_tag_t'(NUM_ARCH + i);
      end
      fl_head  <= '0;
      fl_tail  <= FL_PTR_W'(FL_INIT);
      fl_count <= FL_CNT_W'(FL_INIT);
    end else begin
      // pop on accept, dest now points at the new tag
      if (accept) begin
        map_table[dispatch_op.dest] <= new_tag;
        fl_head <= (fl_head == FL_PTR_W'(NUM_PHYS - 1)) ? '0 : fl_head + 1'b1;
      end
      // push tags released at retire
      if (free_valid) begin
        free_fifo[fl_tail] <= free_tag;
        fl_tail <= (fl_tail == FL_PTR_W'(NUM_PHYS - 1)) ? '0 : fl_tail + 1'b1;
      end
      if (accept && !free_valid) begin
        fl_count <= fl_count - 1'b1;
      end else if (!accept && free_valid) begin
        fl_count <= fl_count + 1'b1;
      end
    end
  end

  ////////////////////
  // rename output register
  ////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      renamed_valid <= 1'b0;
    end else begin
      renamed_valid <= accept;
      if (accept) begin
        renamed.kind     <= dispatch_op.kind;
        // sources read the map before this op's own update
        renamed.tag_a    <= map_table[dispatch_op.src_a];
        renamed.tag_b    <= map_table[dispatch_op.src_b];
        renamed.tag_dest <= new_tag;
        renamed.use_imm  <= dispatch_op.use_imm;
        renamed.imm      <= dispatch_op.imm;
        renamed.rob_idx  <= rob_tail;
        old_tag          <= map_table[dispatch_op.dest];
        renamed_dest     <= dispatch_op.dest;
      end
    end
  end

endmodule

//--- logic/core_pkg.sv
package core_pkg;

  ////////////////////
  // default sizes
  ////////////////////

  // top level takes these as parameter defaults
  localparam int NUM_ARCH   = 8;
  localparam int NUM_PHYS   = 16;
  localparam int ROB_DEPTH  = 8;
  localparam int IQ_DEPTH   = 4;
  localparam int MUL_STAGES = 3;

  ////////////////////
  // value types
  ////////////////////

  typedef logic [2:0]  arch_reg_t;
  typedef logic [3:0]  phys_tag_t;
  typedef logic [31:0] data_t;
  typedef logic [2:0]  rob_idx_t;

  // op_mul goes to the multiplier, the rest to the alu
  typedef enum logic [2:0] {
    op_add,
    op_sub,
    op_and,
    op_xor,
    op_mul
  } op_kind_t;

  ////////////////////
  // stage records
  ////////////////////

  // decoded op as it arrives at dispatch
  typedef struct packed {
    op_kind_t  kind;
    arch_reg_t dest;
    arch_reg_t src_a;
    arch_reg_t src_b;
    logic      use_imm;
    data_t     imm;
  } dispatch_op_t;

  // after the map table lookup
  typedef struct packed {
    op_kind_t  kind;
    phys_tag_t tag_a;
    phys_tag_t tag_b;
    phys_tag_t tag_dest;
    logic      use_imm;
    data_t     imm;
    rob_idx_t  rob_idx;
  } renamed_op_t;

  // operands already resolved, ready for a unit
  typedef struct packed {
    op_kind_t  kind;
    data_t     value_a;
    data_t     value_b;
    phys_tag_t tag_dest;
    rob_idx_t  rob_idx;
  } issue_op_t;

  // one result broadcast per cycle
  typedef struct packed {
    logic      valid;
    phys_tag_t tag;
    rob_idx_t  rob_idx;
    data_t     value;
  } cdb_t;

endpackage
